/* cpu_pkg.sv */
package cpu_pkg;

	// datapath and instruction word width
	localparam int XLEN = 16;
	localparam int REG_AW = 3;
	localparam int OPC_W = 4;
	localparam int IMM_W = 8;

	// opcode sits in inst[15:12]
	typedef enum logic [OPC_W-1:0] {
		OP_NOP   = 4'h0,
		OP_ADDU  = 4'h1,
		OP_SUBU  = 4'h2,
		OP_AND   = 4'h3,
		OP_OR    = 4'h4,
		OP_SLT   = 4'h5,
		OP_LI    = 4'h6,
		OP_ADDIU = 4'h7,
		OP_B     = 4'h8,
		OP_BEQZ  = 4'h9
	} op_t;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_SLT,
		ALU_PASS
	} alu_op_t;

	// active low, bit order gfedcba
	function automatic logic [6:0] seg7_of(input logic [3:0] v);
		case (v)
			4'h0: return 7'b1000000;
			4'h1: return 7'b1111001;
			4'h2: return 7'b0100100;
			4'h3: return 7'b0110000;
			4'h4: return 7'b0011001;
			4'h5: return 7'b0010010;
			4'h6: return 7'b0000010;
			4'h7: return 7'b1111000;
			4'h8: return 7'b0000000;
			4'h9: return 7'b0010000;
			4'ha: return 7'b0001000;
			4'hb: return 7'b0000011;
			4'hc: return 7'b1000110;
			4'hd: return 7'b0100001;
			4'he: return 7'b0000110;
			default: return 7'b0001110;
		endcase
	endfunction

endpackage

/* cpu_if.sv */
`timescale 1ns/1ps

// decode to execute slot, valid low means bubble
interface dx_if
	import cpu_pkg::*;
();
	logic              valid;
	alu_op_t           alu_op;
	logic              is_branch;
	logic              is_cond;
	logic              writes_reg;
	logic [REG_AW-1:0] rd;
	logic [XLEN-1:0]   opa;
	logic [XLEN-1:0]   opb;
	logic [XLEN-1:0]   imm;
	logic [XLEN-1:0]   pc;

	modport dec (output valid, alu_op, is_branch, is_cond, writes_reg, rd, opa, opb, imm, pc);
	modport exe (input valid, alu_op, is_branch, is_cond, writes_reg, rd, opa, opb, imm, pc);
endinterface

// execute to result slot
interface xr_if
	import cpu_pkg::*;
();
	logic              valid;
	logic              writes_reg;
	logic [REG_AW-1:0] rd;
	logic [XLEN-1:0]   value;

	modport exe (output valid, writes_reg, rd, value);
	modport res (input valid, writes_reg, rd, value);
endinterface

/* fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit
	import cpu_pkg::*;
#(
	parameter int IMEM_DEPTH = 256
)(
	input  logic            clk,
	input  logic            reset,
	input  logic            load_en,
	input  logic [XLEN-1:0] load_addr,
	input  logic [XLEN-1:0] load_data,
	input  logic            hold,
	input  logic            flush,
	input  logic [XLEN-1:0] target,
	output logic            f_valid,
	output logic [XLEN-1:0] f_inst,
	output logic [XLEN-1:0] f_pc
);
	localparam int IMEM_AW = $clog2(IMEM_DEPTH);

	logic [XLEN-1:0] imem [IMEM_DEPTH];
	logic [XLEN-1:0] pc;

	// boot port
	always_ff @(posedge clk) begin
		if (load_en) begin
			imem[load_addr[IMEM_AW-1:0]] <= load_data;
		end
	end

	// flush wins over hold, loading wins over both
	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
			f_valid <= 1'b0;
		end else if (load_en) begin
			pc <= '0;
			f_valid <= 1'b0;
		end else if (flush) begin
			pc <= target;
			f_valid <= 1'b0;
		end else if (!hold) begin
			pc <= pc + 1'b1;
			f_valid <= 1'b1;
		end
	end

	// fetch/decode payload
	always_ff @(posedge clk) begin
		if (!hold) begin
			f_inst <= imem[pc[IMEM_AW-1:0]];
			f_pc <= pc;
		end
	end

endmodule

/* register_file.sv */
`timescale 1ns/1ps

module register_file
	import cpu_pkg::*;
(
	input  logic              clk,
	input  logic              reset,
	input  logic [REG_AW-1:0] ra,
	input  logic [REG_AW-1:0] rb,
	input  logic              wr_en,
	input  logic [REG_AW-1:0] wr_addr,
	input  logic [XLEN-1:0]   wr_data,
	output logic [XLEN-1:0]   qa,
	output logic [XLEN-1:0]   qb
);
	logic [XLEN-1:0] regs [2**REG_AW];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 2**REG_AW; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// same-cycle write shows through on reads
	assign qa = (wr_en && wr_addr == ra) ? wr_data : regs[ra];
	assign qb = (wr_en && wr_addr == rb) ? wr_data : regs[rb];

endmodule

/* decode_stage.sv */
`timescale 1ns/1ps

module decode_stage
	import cpu_pkg::*;
(
	input  logic              clk,
	input  logic              reset,
	input  logic              f_valid,
	input  logic [XLEN-1:0]   f_inst,
	input  logic [XLEN-1:0]   f_pc,
	input  logic              flush,
	input  logic              ex_wr,
	input  logic [REG_AW-1:0] ex_rd,
	input  logic              wr_en,
	input  logic [REG_AW-1:0] wr_addr,
	input  logic [XLEN-1:0]   wr_data,
	output logic              hold,
	dx_if.dec                 dx
);
	op_t               opcode;
	logic [REG_AW-1:0] rd;
	logic [REG_AW-1:0] rs;
	logic [REG_AW-1:0] rt;
	logic [REG_AW-1:0] src_a;
	logic [IMM_W-1:0]  imm8;
	logic [XLEN-1:0]   imm_ext;
	logic [XLEN-1:0]   qa;
	logic [XLEN-1:0]   qb;
	alu_op_t           alu_op;
	logic              is_branch;
	logic              is_cond;
	logic              writes_reg;
	logic              use_a;
	logic              use_b;
	logic              use_imm;
	logic              zero_ext;
	logic              hit_a;
	logic              hit_b;

	assign opcode = op_t'(f_inst[15:12]);
	assign rd = f_inst[11:9];
	assign rs = f_inst[8:6];
	assign rt = f_inst[5:3];
	// imm8 overlaps rs and rt
	assign imm8 = f_inst[7:0];

	always_comb begin
		case (opcode)
			OP_SUBU: alu_op = ALU_SUB;
			OP_AND:  alu_op = ALU_AND;
			OP_OR:   alu_op = ALU_OR;
			OP_SLT:  alu_op = ALU_SLT;
			OP_LI:   alu_op = ALU_PASS;
			default: alu_op = ALU_ADD;
		endcase
	end

	always_comb begin
		is_branch = 1'b0;
		is_cond = 1'b0;
		writes_reg = 1'b0;
		use_a = 1'b0;
		use_b = 1'b0;
		use_imm = 1'b0;
		zero_ext = 1'b0;
		src_a = rs;
		case (opcode)
			OP_ADDU, OP_SUBU, OP_AND, OP_OR, OP_SLT: begin
				writes_reg = 1'b1;
				use_a = 1'b1;
				use_b = 1'b1;
			end
			// li zero-extends as in mips16
			OP_LI: begin
				writes_reg = 1'b1;
				zero_ext = 1'b1;
				src_a = rd;
			end
			OP_ADDIU: begin
				writes_reg = 1'b1;
				use_a = 1'b1;
				use_imm = 1'b1;
				src_a = rd;
			end
			OP_B: begin
				is_branch = 1'b1;
			end
			OP_BEQZ: begin
				is_branch = 1'b1;
				is_cond = 1'b1;
				use_a = 1'b1;
				src_a = rd;
			end
			default: ;
		endcase
	end

	assign imm_ext = zero_ext ? {{(XLEN-IMM_W){1'b0}}, imm8}
		: {{(XLEN-IMM_W){imm8[IMM_W-1]}}, imm8};

	register_file u_regs (
		.clk     (clk),
		.reset   (reset),
		.ra      (src_a),
		.rb      (rt),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.qa      (qa),
		.qb      (qb)
	);

	// scoreboard against execute and result slots
	assign hit_a = (ex_wr && ex_rd == src_a) || (wr_en && wr_addr == src_a);
	assign hit_b = (ex_wr && ex_rd == rt) || (wr_en && wr_addr == rt);
	assign hold = f_valid && ((use_a && hit_a) || (use_b && hit_b));

	always_ff @(posedge clk) begin
		if (reset) begin
			dx.valid <= 1'b0;
		end else begin
			dx.valid <= f_valid && !hold && !flush;
		end
	end

	always_ff @(posedge clk) begin
		dx.alu_op <= alu_op;
		dx.is_branch <= is_branch;
		dx.is_cond <= is_cond;
		dx.writes_reg <= writes_reg;
		dx.rd <= rd;
		dx.opa <= qa;
		dx.opb <= use_imm ? imm_ext : qb;
		dx.imm <= imm_ext;
		dx.pc <= f_pc;
	end

endmodule

/* execute_stage.sv */
`timescale 1ns/1ps

module execute_stage
	import cpu_pkg::*;
(
	input  logic              clk,
	input  logic              reset,
	output logic              flush,
	output logic [XLEN-1:0]   target,
	output logic              ex_wr,
	output logic [REG_AW-1:0] ex_rd,
	dx_if.exe                 dx,
	xr_if.exe                 xr
);
	logic [XLEN-1:0] alu_y;
	logic            slt_bit;
	logic            taken;

	assign slt_bit = $signed(dx.opa) < $signed(dx.opb);

	// results wrap to 16 bits
	always_comb begin
		case (dx.alu_op)
			ALU_SUB:  alu_y = dx.opa - dx.opb;
			ALU_AND:  alu_y = dx.opa & dx.opb;
			ALU_OR:   alu_y = dx.opa | dx.opb;
			ALU_SLT:  alu_y = {{(XLEN-1){1'b0}}, slt_bit};
			ALU_PASS: alu_y = dx.imm;
			default:  alu_y = dx.opa + dx.opb;
		endcase
	end

	// beqz tests rd, carried on opa
	assign taken = dx.valid && dx.is_branch && (!dx.is_cond || dx.opa == '0);
	assign flush = taken;
	assign target = dx.pc + 1'b1 + dx.imm;

	// pending destination for the scoreboard
	assign ex_wr = dx.valid && dx.writes_reg;
	assign ex_rd = dx.rd;

	always_ff @(posedge clk) begin
		if (reset) begin
			xr.valid <= 1'b0;
		end else begin
			xr.valid <= dx.valid;
		end
	end

	always_ff @(posedge clk) begin
		xr.writes_reg <= dx.writes_reg;
		xr.rd <= dx.rd;
		xr.value <= alu_y;
	end

endmodule

/* result_stage.sv */
`timescale 1ns/1ps

module result_stage
	import cpu_pkg::*;
(
	input  logic              clk,
	input  logic              reset,
	output logic              wr_en,
	output logic [REG_AW-1:0] wr_addr,
	output logic [XLEN-1:0]   wr_data,
	output logic [XLEN-1:0]   shown,
	xr_if.res                 xr
);

	// one strobe per writing slot
	assign wr_en = xr.valid && xr.writes_reg;
	assign wr_addr = xr.rd;
	assign wr_data = xr.value;

	// last value written, for the display
	always_ff @(posedge clk) begin
		if (reset) begin
			shown <= '0;
		end else if (wr_en) begin
			shown <= xr.value;
		end
	end

endmodule

/* display_drive.sv */
`timescale 1ns/1ps

module display_drive
	import cpu_pkg::*;
(
	input  logic [XLEN-1:0] shown,
	output logic [6:0]      seg1,
	output logic [6:0]      seg2,
	output logic [XLEN-1:0] led
);

	// high nibble on the left digit
	assign seg1 = seg7_of(shown[7:4]);
	assign seg2 = seg7_of(shown[3:0]);

	assign led = shown;

endmodule

/* cpu_top.sv */
`timescale 1ns/1ps

module cpu_top
	import cpu_pkg::*;
#(
	parameter int IMEM_DEPTH = 256
)(
	input  logic              clk,
	input  logic              reset,
	input  logic              load_en,
	input  logic [XLEN-1:0]   load_addr,
	input  logic [XLEN-1:0]   load_data,
	output logic              wb_en,
	output logic [REG_AW-1:0] wb_addr,
	output logic [XLEN-1:0]   wb_data,
	output logic [6:0]        seg1,
	output logic [6:0]        seg2,
	output logic [XLEN-1:0]   led
);
	logic              hold;
	logic              flush;
	logic [XLEN-1:0]   target;
	logic              f_valid;
	logic [XLEN-1:0]   f_inst;
	logic [XLEN-1:0]   f_pc;
	logic              ex_wr;
	logic [REG_AW-1:0] ex_rd;
	logic [XLEN-1:0]   shown;

	dx_if dx ();
	xr_if xr ();

	fetch_unit #(
		.IMEM_DEPTH (IMEM_DEPTH)
	) u_fetch (
		.clk       (clk),
		.reset     (reset),
		.load_en   (load_en),
		.load_addr (load_addr),
		.load_data (load_data),
		.hold      (hold),
		.flush     (flush),
		.target    (target),
		.f_valid   (f_valid),
		.f_inst    (f_inst),
		.f_pc      (f_pc)
	);

	decode_stage u_decode (
		.clk     (clk),
		.reset   (reset),
		.f_valid (f_valid),
		.f_inst  (f_inst),
		.f_pc    (f_pc),
		.flush   (flush),
		.ex_wr   (ex_wr),
		.ex_rd   (ex_rd),
		.wr_en   (wb_en),
		.wr_addr (wb_addr),
		.wr_data (wb_data),
		.hold    (hold),
		.dx      (dx.dec)
	);

	execute_stage u_execute (
		.clk    (clk),
		.reset  (reset),
		.flush  (flush),
		.target (target),
		.ex_wr  (ex_wr),
		.ex_rd  (ex_rd),
		.dx     (dx.exe),
		.xr     (xr.exe)
	);

	// write strobe also goes out as wb_*
	result_stage u_result (
		.clk     (clk),
		.reset   (reset),
		.wr_en   (wb_en),
		.wr_addr (wb_addr),
		.wr_data (wb_data),
		.shown   (shown),
		.xr      (xr.res)
	);

	display_drive u_display (
		.shown (shown),
		.seg1  (seg1),
		.seg2  (seg2),
		.led   (led)
	);

endmodule

/* tb_cpu.sv */
`timescale 1ns/1ps

module tb_cpu
	import cpu_pkg::*;
();
	localparam int CLK_PERIOD = 20;
	localparam int DRIVE_DELAY = 2;
	localparam int RESET_CYCLES = 5;
	localparam int IMEM_DEPTH = 256;
	localparam int PROG_LEN = 60;
	localparam int HALT_PC = PROG_LEN - 1;
	// two nop words past the halt loop fill its fetch shadow
	localparam int LOAD_WORDS = PROG_LEN + 2;
	localparam int QUIET_CYCLES = 50;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + LOAD_WORDS + PROG_LEN * 8 + 200;
	localparam logic [31:0] SEED = 32'haae6_1588;

	logic        clk = 1'b0;
	logic        reset;
	logic        load_en;
	logic [15:0] load_addr;
	logic [15:0] load_data;
	logic        wb_en;
	logic [2:0]  wb_addr;
	logic [15:0] wb_data;
	logic [6:0]  seg1;
	logic [6:0]  seg2;
	logic [15:0] led;

	logic [15:0] prog [LOAD_WORDS];
	// {addr, value} in program order
	logic [18:0] exp_q [$];
	logic [18:0] entry;
	logic [15:0] shown_exp = '0;
	int          wb_seen = 0;
	int          wb_total = 0;

	cpu_top #(
		.IMEM_DEPTH (IMEM_DEPTH)
	) uut (
		.clk       (clk),
		.reset     (reset),
		.load_en   (load_en),
		.load_addr (load_addr),
		.load_data (load_data),
		.wb_en     (wb_en),
		.wb_addr   (wb_addr),
		.wb_data   (wb_data),
		.seg1      (seg1),
		.seg2      (seg2),
		.led       (led)
	);

	initial begin
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic stop_run(input string reason);
		$display("Checks failed");
		$fatal(1, "%s", reason);
	endtask

	task automatic report_value(input string name, input logic [15:0] got,
			input logic [15:0] exp);
		$display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
		stop_run("output value mismatch");
	endtask

	// active low gfedcba segments for hex digits
	function automatic logic [6:0] expected_segments(input logic [3:0] v);
		logic [6:0] table_seg [16];
		table_seg = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
			7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e};
		return table_seg[v];
	endfunction

	function automatic logic [15:0] encode_r(input op_t op, input logic [2:0] rd,
			input logic [2:0] rs, input logic [2:0] rt);
		return {op, rd, rs, rt, 3'b000};
	endfunction

	function automatic logic [15:0] encode_i(input op_t op, input logic [2:0] rd,
			input logic [7:0] imm);
		return {op, rd, 1'b0, imm};
	endfunction

	task automatic build_program();
		logic [31:0] r;
		logic [2:0]  last_rd;
		logic [2:0]  rd;
		logic [2:0]  rs;
		logic [2:0]  rt;
		logic [7:0]  imm;
		int unsigned pick;
		int unsigned off;
		last_rd = 3'd0;
		for (int i = 0; i < HALT_PC; i++) begin
			r = $urandom;
			rd = r[2:0];
			rs = r[5:3];
			rt = r[8:6];
			imm = r[16:9];
			// lean on the previous destination to provoke stalls
			if (r[17]) begin
				rs = last_rd;
			end
			if (r[18] && r[19]) begin
				rt = last_rd;
			end
			pick = $urandom_range(99);
			if (pick < 45) begin
				case (pick % 5)
					0: prog[i] = encode_r(OP_ADDU, rd, rs, rt);
					1: prog[i] = encode_r(OP_SUBU, rd, rs, rt);
					2: prog[i] = encode_r(OP_AND, rd, rs, rt);
					3: prog[i] = encode_r(OP_OR, rd, rs, rt);
					default: prog[i] = encode_r(OP_SLT, rd, rs, rt);
				endcase
				last_rd = rd;
			end else if (pick < 60) begin
				// zero values give beqz something to take
				if (r[23:22] == 2'b00) begin
					imm = 8'h00;
				end
				prog[i] = encode_i(OP_LI, rd, imm);
				last_rd = rd;
			end else if (pick < 75) begin
				prog[i] = encode_i(OP_ADDIU, r[17] ? last_rd : rd, imm);
				last_rd = r[17] ? last_rd : rd;
			end else if (pick < 95) begin
				// forward only and never past the halt loop
				off = $urandom_range((HALT_PC - 1 - i) < 3 ? (HALT_PC - 1 - i) : 3);
				if (pick < 82) begin
					prog[i] = encode_i(OP_B, 3'd0, off[7:0]);
				end else begin
					prog[i] = encode_i(OP_BEQZ, r[17] ? last_rd : rd, off[7:0]);
				end
			end else begin
				prog[i] = 16'h0000;
			end
		end
		prog[HALT_PC] = encode_i(OP_B, 3'd0, 8'hff);
		prog[HALT_PC + 1] = 16'h0000;
		prog[HALT_PC + 2] = 16'h0000;
	endtask

	// instruction-level interpreter stepping one instruction at a time
	task automatic run_model();
		logic [15:0] regs [8];
		logic [15:0] w;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] val;
		logic [2:0]  rd;
		logic        wr;
		int          pc;
		int          next_pc;
		int          off;
		int          steps;
		for (int k = 0; k < 8; k++) begin
			regs[k] = '0;
		end
		pc = 0;
		steps = 0;
		while (1) begin
			w = prog[pc];
			rd = w[11:9];
			a = regs[w[8:6]];
			b = regs[w[5:3]];
			off = int'($signed(w[7:0]));
			val = '0;
			wr = 1'b1;
			next_pc = pc + 1;
			case (w[15:12])
				OP_ADDU:  val = a + b;
				OP_SUBU:  val = a - b;
				OP_AND:   val = a & b;
				OP_OR:    val = a | b;
				OP_SLT:   val = ($signed(a) < $signed(b)) ? 16'd1 : 16'd0;
				OP_LI:    val = {8'h00, w[7:0]};
				OP_ADDIU: val = regs[rd] + {{8{w[7]}}, w[7:0]};
				OP_B: begin
					wr = 1'b0;
					next_pc = pc + 1 + off;
				end
				OP_BEQZ: begin
					wr = 1'b0;
					if (regs[rd] == 16'h0000) begin
						next_pc = pc + 1 + off;
					end
				end
				default: wr = 1'b0;
			endcase
			if (next_pc == pc) begin
				break;
			end
			if (wr) begin
				regs[rd] = val;
				exp_q.push_back({rd, val});
			end
			pc = next_pc;
			steps++;
			if (steps > 4 * PROG_LEN) begin
				stop_run("reference model never reached the halt loop");
			end
		end
	endtask

	task automatic boot_load();
		for (int i = 0; i < LOAD_WORDS; i++) begin
			load_en = 1'b1;
			load_addr = 16'(i);
			load_data = prog[i];
			@(posedge clk);
			#(DRIVE_DELAY);
		end
		load_en = 1'b0;
	endtask

	// outputs settle between edges
	always @(negedge clk) begin
		if (reset || load_en) begin
			assert (!wb_en) else stop_run("write-back strobe during reset or boot load");
		end
		assert (led == shown_exp) else report_value("led", led, shown_exp);
		assert (seg1 == expected_segments(shown_exp[7:4]))
			else report_value("seg1", 16'(seg1), 16'(expected_segments(shown_exp[7:4])));
		assert (seg2 == expected_segments(shown_exp[3:0]))
			else report_value("seg2", 16'(seg2), 16'(expected_segments(shown_exp[3:0])));
		if (wb_en) begin
			assert (exp_q.size() > 0)
				else stop_run("write-back arrived that the model never made");
			entry = exp_q.pop_front();
			assert (wb_addr == entry[18:16])
				else report_value("wb_addr", 16'(wb_addr), 16'(entry[18:16]));
			assert (wb_data == entry[15:0])
				else report_value("wb_data", wb_data, entry[15:0]);
			shown_exp = entry[15:0];
			wb_seen++;
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		stop_run("timeout before the program finished its write-backs");
	end

	initial begin
		reset = 1'b1;
		load_en = 1'b0;
		load_addr = '0;
		load_data = '0;
		void'($urandom(SEED));
		build_program();
		run_model();
		wb_total = exp_q.size();
		repeat (RESET_CYCLES) @(posedge clk);
		#(DRIVE_DELAY);
		reset = 1'b0;
		boot_load();
		while (wb_seen < wb_total) begin
			@(negedge clk);
		end
		// nothing more may write back while the halt loop spins
		repeat (QUIET_CYCLES) @(negedge clk);
		$display("All checks passed");
		$finish;
	end

endmodule

/* compile.f */
cpu_pkg.sv
cpu_if.sv
fetch_unit.sv
register_file.sv
decode_stage.sv
execute_stage.sv
result_stage.sv
display_drive.sv
cpu_top.sv
tb_cpu.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_cpu
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert --timescale 1ns/1ps
PASS_MSG  ?= All checks passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
